//--- dv/indicator_checker.sv
//**********************************************************
// Frame monitor for the indicator testbench
// Counts high cycles of every pwm_out bit between frame ends and
// compares them with fixed levels, a steady display or a sweep
//**********************************************************

`timescale 1ns/10ps
`include "indicator_macros.svh"

module indicator_checker (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          frame_end,
	input  logic [`IND_CHANNELS-1:0]                      pwm_out,
	input  logic [1:0]                                    mode,
	input  indicator_cfg_pkg::level_t [`IND_CHANNELS-1:0] exp_level,
	output int                                            frames,
	output int                                            checked,
	output int                                            errors
);

	// Check modes, same coding as in the testbench
	localparam logic [1:0] MODE_OFF    = 2'd0;
	localparam logic [1:0] MODE_FIXED  = 2'd1;
	localparam logic [1:0] MODE_SWEEP  = 2'd2;
	localparam logic [1:0] MODE_STEADY = 2'd3;

	int         cnt [`IND_CHANNELS];
	int         prev [`IND_CHANNELS];
	logic [1:0] win_mode;
	logic       open;
	logic       have_prev;
	logic       seen_step;
	// Compared sweep frames since the last level step
	int         still;

	// Judge one finished frame against the mode it started in
	task automatic judge_frame();
		int   want;
		int   delta;
		logic moved;
		moved = 1'b0;
		for (int b = 0; b < `IND_CHANNELS; b++) begin
			if (have_prev && cnt[b] != prev[b]) begin
				moved = 1'b1;
			end
		end
		for (int b = 0; b < `IND_CHANNELS; b++) begin
			// Bit b carries channel CHANNELS-1-b
			want = exp_level[`IND_CHANNELS-1-b] * `IND_PWM_DIV;
			delta = cnt[b] - prev[b];
			if (win_mode == MODE_FIXED && cnt[b] != want) begin
				$display("Error: pwm_out[%0d] high count 0x%h, expected 0x%h", b, cnt[b], want);
				errors++;
			end else if (win_mode == MODE_STEADY && have_prev && delta != 0) begin
				$display("Error: pwm_out[%0d] high count 0x%h, expected 0x%h", b, cnt[b], prev[b]);
				errors++;
			end else if (win_mode == MODE_SWEEP && moved &&
				delta != `IND_PWM_DIV && delta != -`IND_PWM_DIV) begin
				$display("Error: pwm_out[%0d] high count 0x%h after 0x%h, not one level step",
					b, cnt[b], prev[b]);
				errors++;
			end
		end
		// Step spacing in sweep, first step may come anywhere in a group
		if (win_mode == MODE_SWEEP && have_prev) begin
			if (moved) begin
				if (seen_step && still != `IND_STEP_DIV - 1) begin
					$display("Sweep step came %0d frames after the previous one, not %0d",
						still + 1, `IND_STEP_DIV);
					errors++;
				end
				seen_step = 1'b1;
				still = 0;
			end else begin
				still++;
				if (still == `IND_STEP_DIV) begin
					$display("Sweep levels did not change within %0d frames", still);
					errors++;
				end
			end
		end
		prev = cnt;
		have_prev = 1'b1;
	endtask

	//**********************************************************
	// Frame windows
	//**********************************************************

	// Boundary states of a frame are always dark, so any window
	// between two frame ends holds exactly one displayed level
	always @(posedge clk) begin
		if (!rst_n) begin
			open = 1'b0;
			have_prev = 1'b0;
			seen_step = 1'b0;
			still = 0;
			frames = 0;
			checked = 0;
			errors = 0;
		end else begin
			if (frame_end) begin
				if (open && win_mode != MODE_OFF && win_mode == mode) begin
					judge_frame();
					checked++;
				end else begin
					have_prev = 1'b0;
					seen_step = 1'b0;
					still = 0;
				end
				frames++;
				open = 1'b1;
				win_mode = mode;
				for (int b = 0; b < `IND_CHANNELS; b++) begin
					cnt[b] = 0;
				end
			end
			for (int b = 0; b < `IND_CHANNELS; b++) begin
				if (open && pwm_out[b] === 1'b1) begin
					cnt[b]++;
				end
			end
		end
	end

endmodule

//--- dv/indicator_tb.sv
//**********************************************************
// Testbench for the LED breathing indicators
// Applies a table of enable, preset and dwell rows, derives the
// expected levels and lets the checker measure every frame
//**********************************************************

`timescale 1ns/10ps
`include "indicator_macros.svh"

module indicator_tb;

	localparam int          SEED         = 30126;
	localparam int          ROW_COUNT    = 14;
	localparam int          CLK_PERIOD   = 20;
	localparam int          FRAME_CYCLES = (1 << `IND_RESOLUTION) * `IND_PWM_DIV;
	// Reset time plus the preset cycles of all rows
	localparam longint      MARGIN_NS    = 40000;
	localparam logic [1:0]  MODE_OFF     = 2'd0;
	localparam logic [1:0]  MODE_FIXED   = 2'd1;
	localparam logic [1:0]  MODE_SWEEP   = 2'd2;
	localparam logic [1:0]  MODE_STEADY  = 2'd3;

	// One stimulus row, dwell counted in frames
	typedef struct packed {
		logic                      enable;
		logic                      preset;
		logic                      lcg;
		indicator_cfg_pkg::phase_t phase;
		logic [7:0]                frames;
		logic [1:0]                mode;
	} row_t;

	localparam row_t ROWS [ROW_COUNT] = '{
		// Idle with a phase waiting, must stay dark
		'{1'b0, 1'b0, 1'b0, 9'd200, 8'd3, MODE_FIXED},
		// Presets from idle, then in hold
		'{1'b0, 1'b1, 1'b0, 9'd0, 8'd3, MODE_FIXED},
		'{1'b0, 1'b1, 1'b0, 9'd255, 8'd3, MODE_FIXED},
		'{1'b0, 1'b1, 1'b0, 9'd256, 8'd3, MODE_FIXED},
		'{1'b0, 1'b1, 1'b0, 9'd509, 8'd3, MODE_FIXED},
		'{1'b0, 1'b1, 1'b1, 9'd0, 8'd3, MODE_FIXED},
		'{1'b0, 1'b1, 1'b1, 9'd0, 8'd3, MODE_FIXED},
		// Out of range, reduced by the DUT
		'{1'b0, 1'b1, 1'b0, 9'd511, 8'd3, MODE_FIXED},
		'{1'b1, 1'b0, 1'b0, 9'd0, 8'd14, MODE_SWEEP},
		'{1'b0, 1'b0, 1'b0, 9'd0, 8'd4, MODE_STEADY},
		// Reload in hold, then sweep across the wrap at 509
		'{1'b0, 1'b1, 1'b0, 9'd128, 8'd3, MODE_FIXED},
		'{1'b0, 1'b1, 1'b0, 9'd507, 8'd3, MODE_FIXED},
		'{1'b1, 1'b0, 1'b0, 9'd0, 8'd18, MODE_SWEEP},
		'{1'b0, 1'b0, 1'b0, 9'd0, 8'd4, MODE_STEADY}
	};

	logic                                          clk;
	logic                                          rst_n;
	logic                                          enable;
	logic                                          preset;
	indicator_cfg_pkg::phase_t                     preset_phase;
	logic [`IND_CHANNELS-1:0]                      pwm_out;
	logic [1:0]                                    check_mode;
	indicator_cfg_pkg::level_t [`IND_CHANNELS-1:0] exp_level;
	int                                            frames;
	int                                            checked;
	int                                            errors;
	int                                            tb_errors;
	logic [31:0]                                   lcg_state;
	int                                            model_phase;
	// Set once the LEDs may light
	logic                                          lit;

	indicator_top i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.enable       (enable),
		.preset       (preset),
		.preset_phase (preset_phase),
		.pwm_out      (pwm_out)
	);

	// Frame boundaries taken from the timer tick
	indicator_checker i_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.frame_end (i_dut.ticks.frame_end),
		.pwm_out   (pwm_out),
		.mode      (check_mode),
		.exp_level (exp_level),
		.frames    (frames),
		.checked   (checked),
		.errors    (errors)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Triangle rule: rising up to the peak, then back down
	function automatic int fold_expect(input int base, input int ch);
		int p;
		p = (base + ch * `IND_CH_OFFSET) % `IND_PHASE_MOD;
		return (p <= `IND_MAX_LEVEL) ? p : `IND_PHASE_MOD - p;
	endfunction

	function automatic int total_frames();
		int sum;
		sum = 0;
		for (int r = 0; r < ROW_COUNT; r++) begin
			sum += ROWS[r].frames + 1;
		end
		return sum;
	endfunction

	// Frames the checker judges, first one after the mode change is skipped
	function automatic int expected_checks();
		int sum;
		sum = 0;
		for (int r = 0; r < ROW_COUNT; r++) begin
			sum += ROWS[r].frames - 1;
		end
		return sum;
	endfunction

	task automatic wait_frames(input int n);
		int target;
		target = frames + n;
		while (frames < target) begin
			@(negedge clk);
		end
	endtask

	task automatic apply_row(input row_t r);
		indicator_cfg_pkg::phase_t ph;
		ph = r.phase;
		if (r.lcg) begin
			lcg_state = lcg_step(lcg_state);
			ph = lcg_state[24:16];
		end
		check_mode = MODE_OFF;
		enable = r.enable;
		preset_phase = ph;
		if (r.preset) begin
			preset = 1'b1;
			@(negedge clk);
			preset = 1'b0;
			model_phase = ph % `IND_PHASE_MOD;
		end
		if (r.enable || r.preset) begin
			lit = 1'b1;
		end
		for (int i = 0; i < `IND_CHANNELS; i++) begin
			exp_level[i] = lit ? fold_expect(model_phase, i) : 0;
		end
		// One frame to settle, then check for the rest of the dwell
		wait_frames(1);
		check_mode = r.mode;
		wait_frames(r.frames);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//**********************************************************
	// Stimulus
	//**********************************************************

	initial begin
		rst_n = 1'b0;
		enable = 1'b0;
		preset = 1'b0;
		preset_phase = '0;
		check_mode = MODE_OFF;
		exp_level = '0;
		lcg_state = SEED;
		model_phase = 0;
		lit = 1'b0;
		tb_errors = 0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		for (int r = 0; r < ROW_COUNT; r++) begin
			apply_row(ROWS[r]);
		end
		check_mode = MODE_OFF;
		if (checked != expected_checks()) begin
			$display("Checker judged %0d frames instead of %0d", checked, expected_checks());
			tb_errors++;
		end
		$display("Errors: %0d in checker, %0d in testbench", errors, tb_errors);
		if (errors + tb_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Twice the scheduled run time plus margin
	initial begin
		longint limit;
		limit = longint'(total_frames()) * FRAME_CYCLES * CLK_PERIOD * 2 + MARGIN_NS;
		#(limit);
		$display("Watchdog expired after %0d ns, stimulus did not complete", limit);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- hw/indicator_cfg_pkg.sv
//**********************************************************
// Value types of the indicator design
// Widths of levels, phase and counters, plus controller states
//**********************************************************

`include "indicator_macros.svh"

package indicator_cfg_pkg;

	// Brightness of one channel
	typedef logic [`IND_RESOLUTION-1:0] level_t;

	// Position within the triangle, one bit wider than a level
	typedef logic [`IND_RESOLUTION:0] phase_t;

	// PWM tick prescaler, counts up to IND_PWM_DIV - 1
	typedef logic [$clog2(`IND_PWM_DIV + 1)-1:0] prescale_t;

	// Frames between phase steps
	typedef logic [$clog2(`IND_STEP_DIV + 1)-1:0] step_cnt_t;

	// Controller modes
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_SWEEP = 2'd1,
		ST_HOLD  = 2'd2
	} ind_state_e;

endpackage

//--- hw/indicator_fsm.sv
//**********************************************************
// Controller for the breathing pattern
// Chooses dark, running or frozen display from enable and preset
//**********************************************************

`timescale 1ns/10ps

module indicator_fsm (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       enable,
	input  logic                       preset,
	output indicator_io_pkg::ind_cmd_t cmd
);

	indicator_cfg_pkg::ind_state_e state;
	indicator_cfg_pkg::ind_state_e state_next;
	logic                          load_q;

	//**********************************************************
	// Next state
	//**********************************************************

	always_comb begin
		state_next = state;
		case (state)
			indicator_cfg_pkg::ST_IDLE: begin
				// Preset wins so the load lands in hold
				if (preset) begin
					state_next = indicator_cfg_pkg::ST_HOLD;
				end else if (enable) begin
					state_next = indicator_cfg_pkg::ST_SWEEP;
				end
			end
			indicator_cfg_pkg::ST_SWEEP: begin
				if (!enable) begin
					state_next = indicator_cfg_pkg::ST_HOLD;
				end
			end
			indicator_cfg_pkg::ST_HOLD: begin
				// Stay one more cycle when a preset comes in
				if (enable && !preset) begin
					state_next = indicator_cfg_pkg::ST_SWEEP;
				end
			end
			default: begin
				state_next = indicator_cfg_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= indicator_cfg_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Load pulse, one cycle after an accepted preset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			load_q <= 1'b0;
		end else begin
			load_q <= preset && (state != indicator_cfg_pkg::ST_SWEEP);
		end
	end

	// Command outputs straight from state
	assign cmd.run        = (state == indicator_cfg_pkg::ST_SWEEP);
	assign cmd.load       = load_q;
	assign cmd.outputs_on = (state != indicator_cfg_pkg::ST_IDLE);

	// Phase reload never competes with stepping
	a_no_load_in_sweep: assert property (@(posedge clk) disable iff (!rst_n)
		cmd.load |-> (state != indicator_cfg_pkg::ST_SWEEP));

endmodule

//--- hw/indicator_io_pkg.sv
//**********************************************************
// Signal bundles passed between the indicator blocks
//**********************************************************

package indicator_io_pkg;

	// Enable ticks from the timer, all one-cycle pulses
	typedef struct packed {
		logic pwm_tick;
		logic frame_end;
		logic step_tick;
	} tick_bus_t;

	// Controller commands
	typedef struct packed {
		// Phase advances on step ticks
		logic run;
		// One-cycle load of the preset phase
		logic load;
		// LEDs may light
		logic outputs_on;
	} ind_cmd_t;

endpackage

//--- hw/indicator_top.sv
//**********************************************************
// Front-panel LED breathing indicators, top level
// Drive enable as a level and preset as a one-cycle strobe
//**********************************************************

`timescale 1ns/10ps
`include "indicator_macros.svh"

module indicator_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            enable,
	input  logic                            preset,
	input  indicator_cfg_pkg::phase_t       preset_phase,
	output logic [`IND_CHANNELS-1:0]        pwm_out
);

	indicator_io_pkg::tick_bus_t                    ticks;
	indicator_io_pkg::ind_cmd_t                     cmd;
	indicator_cfg_pkg::level_t [`IND_CHANNELS-1:0]  levels;

	// Tick generation, steps only while running
	tick_timer i_timer (
		.clk   (clk),
		.rst_n (rst_n),
		.run   (cmd.run),
		.ticks (ticks)
	);

	// Mode control
	indicator_fsm i_fsm (
		.clk    (clk),
		.rst_n  (rst_n),
		.enable (enable),
		.preset (preset),
		.cmd    (cmd)
	);

	triangle_phase i_phase (
		.clk          (clk),
		.rst_n        (rst_n),
		.ticks        (ticks),
		.cmd          (cmd),
		.preset_phase (preset_phase),
		.levels       (levels)
	);

	// LED drivers
	pwm_bank i_pwm (
		.clk        (clk),
		.rst_n      (rst_n),
		.ticks      (ticks),
		.outputs_on (cmd.outputs_on),
		.levels     (levels),
		.pwm_out    (pwm_out)
	);

endmodule

//--- hw/pwm_bank.sv
//**********************************************************
// PWM output stage for all channels
// One shared counter, levels latched per frame, outputs registered
// with channel i on bit IND_CHANNELS - 1 - i
//**********************************************************

`timescale 1ns/10ps
`include "indicator_macros.svh"

module pwm_bank (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  indicator_io_pkg::tick_bus_t                   ticks,
	input  logic                                          outputs_on,
	input  indicator_cfg_pkg::level_t [`IND_CHANNELS-1:0] levels,
	output logic [`IND_CHANNELS-1:0]                      pwm_out
);

	indicator_cfg_pkg::level_t                      pwm_cnt;
	indicator_cfg_pkg::level_t [`IND_CHANNELS-1:0]  level_q;

	//**********************************************************
	// Shared counter and frame latch
	//**********************************************************

	// Wraps together with the timer frame counter
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pwm_cnt <= '0;
		end else if (ticks.pwm_tick) begin
			pwm_cnt <= pwm_cnt + 1'b1;
		end
	end

	// New levels only at a frame boundary
	always_ff @(posedge clk) begin
		if (ticks.frame_end) begin
			level_q <= levels;
		end
	end

	//**********************************************************
	// Compare per channel
	//**********************************************************

	// High for level counts of each frame
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pwm_out <= '0;
		end else begin
			for (int unsigned i = 0; i < `IND_CHANNELS; i++) begin
				pwm_out[`IND_CHANNELS-1-i] <= outputs_on && (pwm_cnt < level_q[i]);
			end
		end
	end

endmodule

//--- hw/tick_timer.sv
//**********************************************************
// Enable tick generator for the indicators
// Prescales clk into PWM ticks, marks frame ends and, while run
// is high, emits a phase step every IND_STEP_DIV frames
//**********************************************************

`timescale 1ns/10ps
`include "indicator_macros.svh"

module tick_timer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        run,
	output indicator_io_pkg::tick_bus_t ticks
);

	indicator_cfg_pkg::prescale_t prescale;
	indicator_cfg_pkg::level_t    frame_cnt;
	indicator_cfg_pkg::step_cnt_t step_cnt;
	logic                         pre_wrap;
	logic                         frame_wrap;
	logic                         step_wrap;

	// Wrap conditions, ticks are registered copies of these
	assign pre_wrap   = (prescale == indicator_cfg_pkg::prescale_t'(`IND_PWM_DIV - 1));
	assign frame_wrap = pre_wrap &&
		(frame_cnt == indicator_cfg_pkg::level_t'(`IND_MAX_LEVEL));
	assign step_wrap  = frame_wrap && run &&
		(step_cnt == indicator_cfg_pkg::step_cnt_t'(`IND_STEP_DIV - 1));

	//**********************************************************
	// Counters
	//**********************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prescale <= '0;
		end else if (pre_wrap) begin
			prescale <= '0;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	// Frame position, wraps naturally at 2^R ticks
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			frame_cnt <= '0;
		end else if (pre_wrap) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// Frames only counted while running, held otherwise
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step_cnt <= '0;
		end else if (frame_wrap && run) begin
			step_cnt <= step_wrap ? '0 : step_cnt + 1'b1;
		end
	end

	// Registered tick outputs
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ticks <= '0;
		end else begin
			ticks.pwm_tick  <= pre_wrap;
			ticks.frame_end <= frame_wrap;
			ticks.step_tick <= step_wrap;
		end
	end

	// Tick nesting seen by the PWM bank and the phase unit
	a_step_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		ticks.step_tick |-> ticks.frame_end);
	a_frame_on_tick: assert property (@(posedge clk) disable iff (!rst_n)
		ticks.frame_end |-> ticks.pwm_tick);

endmodule

//--- hw/triangle_phase.sv
//**********************************************************
// Shared phase and per-channel triangle fold
// Steps or reloads one phase and turns it into registered levels,
// each channel shifted by an even share of the triangle
//**********************************************************

`timescale 1ns/10ps
`include "indicator_macros.svh"

module triangle_phase (
	input  logic                                             clk,
	input  logic                                             rst_n,
	input  indicator_io_pkg::tick_bus_t                      ticks,
	input  indicator_io_pkg::ind_cmd_t                       cmd,
	input  indicator_cfg_pkg::phase_t                        preset_phase,
	output indicator_cfg_pkg::level_t [`IND_CHANNELS-1:0]    levels
);

	indicator_cfg_pkg::phase_t phase;
	indicator_cfg_pkg::phase_t preset_q;

	// Reduce a raw phase into the triangle length
	function automatic indicator_cfg_pkg::phase_t wrap_phase(
		input indicator_cfg_pkg::phase_t raw
	);
		if (raw >= `IND_PHASE_MOD) begin
			return indicator_cfg_pkg::phase_t'(raw - `IND_PHASE_MOD);
		end
		return raw;
	endfunction

	// Level of channel idx for a given shared phase
	function automatic indicator_cfg_pkg::level_t fold_level(
		input indicator_cfg_pkg::phase_t base,
		input int unsigned               idx
	);
		logic [`IND_RESOLUTION+1:0] sum;
		indicator_cfg_pkg::phase_t  ch;
		sum = (`IND_RESOLUTION + 2)'(base + `IND_CH_OFFSET * idx);
		// Offset stays below one triangle, one subtraction is enough
		if (sum >= `IND_PHASE_MOD) begin
			sum = sum - (`IND_RESOLUTION + 2)'(`IND_PHASE_MOD);
		end
		ch = indicator_cfg_pkg::phase_t'(sum);
		// Falling half of the triangle
		if (ch > `IND_MAX_LEVEL) begin
			return indicator_cfg_pkg::level_t'(`IND_PHASE_MOD - ch);
		end
		return indicator_cfg_pkg::level_t'(ch);
	endfunction

	//**********************************************************
	// Phase register
	//**********************************************************

	// Preset value captured in the strobe cycle, load follows one later
	always_ff @(posedge clk) begin
		preset_q <= wrap_phase(preset_phase);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (cmd.load) begin
			phase <= preset_q;
		end else if (cmd.run && ticks.step_tick) begin
			phase <= (phase == indicator_cfg_pkg::phase_t'(`IND_PHASE_MOD - 1)) ?
				'0 : phase + 1'b1;
		end
	end

	// Levels follow the phase one clk later
	always_ff @(posedge clk) begin
		for (int unsigned i = 0; i < `IND_CHANNELS; i++) begin
			levels[i] <= fold_level(phase, i);
		end
	end

	a_phase_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		phase < `IND_PHASE_MOD);

endmodule

//--- include/indicator_macros.svh
//**********************************************************
// Build-time constants for the LED breathing indicators
// Include wherever channel count, resolution or rates are needed
//**********************************************************

`ifndef INDICATOR_MACROS_SVH
`define INDICATOR_MACROS_SVH

// Number of LED channels on the panel row
`define IND_CHANNELS    8

// PWM resolution in bits
`define IND_RESOLUTION  8

// clk cycles per PWM tick
`define IND_PWM_DIV     2

// PWM frames per phase step
`define IND_STEP_DIV    4

// Brightest level, 2^R - 1
`define IND_MAX_LEVEL   ((1 << `IND_RESOLUTION) - 1)

// Length of one full triangle, up and down
`define IND_PHASE_MOD   ((2 << `IND_RESOLUTION) - 2)

// Phase distance between neighbouring channels
`define IND_CH_OFFSET   (`IND_PHASE_MOD / `IND_CHANNELS)

`endif

//--- verilog.f
+incdir+include
hw/indicator_cfg_pkg.sv
hw/indicator_io_pkg.sv
hw/tick_timer.sv
hw/indicator_fsm.sv
hw/triangle_phase.sv
hw/pwm_bank.sv
hw/indicator_top.sv
dv/indicator_checker.sv
dv/indicator_tb.sv
